// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bench_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+hdl
hdl/bench_pkg.sv
hdl/kernel_ram.sv
hdl/scaled_mac_kernel.sv
hdl/signature_reducer.sv
hdl/bench_top.sv
verification/bench_checker.sv
verification/tb_bench_top.sv

// ==== verification/tb_bench_top.sv ====
`timescale 1ns/1ps
`include "bench_settings.svh"

module tb_bench_top;

    localparam int RESET_CYCLES = 10;
    localparam int N_RUNS       = 18;
    localparam int VALUE_RUNS   = 10;
    // each run, a refill and some slack, plus the reset
    localparam int CYCLE_LIMIT  = N_RUNS * (2 * `BENCH_BANK_DEPTH + 16) + RESET_CYCLES;

    logic               ap_clk;
    logic               arst_n;
    logic               ap_start;
    bench_pkg::word_t   alpha;
    bench_pkg::word_t   beta;
    logic               ap_done;
    logic               ap_idle;
    bench_pkg::nibble_t data_out;
    logic               data_valid;

    int cycles = 0;
    int fails;

    initial
    begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    bench_top uut (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .ap_start   (ap_start),
        .alpha      (alpha),
        .beta       (beta),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    bench_checker #(
        .N_RUNS     (N_RUNS),
        .VALUE_RUNS (VALUE_RUNS)
    ) chk (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .ap_start   (ap_start),
        .alpha      (alpha),
        .beta       (beta),
        .ap_done    (ap_done),
        .ap_idle    (ap_idle),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

    // ##############################
    // stimulus helpers

    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    // hold start with fresh operands until the DUT leaves idle
    task automatic start_run();
        ap_start = 1'b1;
        alpha    = $urandom();
        beta     = $urandom();
        do
        begin
            next_cycle();
            if (ap_idle)
            begin
                alpha = $urandom();
                beta  = $urandom();
            end
        end
        while (ap_idle);
        ap_start = 1'b0;
    endtask

    // one stray start somewhere inside the sweep
    task automatic poke_busy_start();
        int gap;
        gap = 5 + ($urandom() % 40);
        repeat (gap) next_cycle();
        ap_start = 1'b1;
        alpha    = $urandom();
        beta     = $urandom();
        next_cycle();
        ap_start = 1'b0;
    endtask

    task automatic wait_done();
        while (!ap_done)
            next_cycle();
    endtask

    // ##############################
    // main sequence

    initial
    begin
        void'($urandom(32'hc376250f));
        arst_n   = 1'b0;
        ap_start = 1'b0;
        alpha    = '0;
        beta     = '0;
        repeat (RESET_CYCLES) @(posedge ap_clk);
        #1;
        arst_n = 1'b1;
        // quiet while the banks fill, then starts go in early
        repeat (20) next_cycle();
        for (int r = 0; r < N_RUNS; r++)
        begin
            start_run();
            poke_busy_start();
            wait_done();
        end
        // tail of the last signature stream
        repeat (8) next_cycle();
        chk.print_summary(fails);
        if (fails == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    always @(posedge ap_clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

endmodule

// ==== verification/bench_checker.sv ====
`timescale 1ns/1ps
`include "bench_settings.svh"

module bench_checker #(
    parameter int N_RUNS     = 18,
    parameter int VALUE_RUNS = 10
) (
    input logic               ap_clk,
    input logic               arst_n,
    input logic               ap_start,
    input bench_pkg::word_t   alpha,
    input bench_pkg::word_t   beta,
    input logic               ap_done,
    input logic               ap_idle,
    input bench_pkg::nibble_t data_out,
    input logic               data_valid
);

    localparam int DEPTH    = `BENCH_BANK_DEPTH;
    localparam int MAX_RUNS = 4 * N_RUNS;

    // model state stepped once per clock cycle
    int   cyc;
    int   fill_left;
    int   done_cnt;
    int   done_total;
    int   dut_dones;
    int   runs;
    int   ignored;
    int   busy_from;
    int   busy_until;
    int   dataset;
    int   run;
    logic exp_done;
    logic exp_idle;
    logic exp_valid;
    logic loaded;
    logic refill;
    bench_pkg::nibble_t nib;

    // expected events tagged with their cycle
    int                 exp_cyc_q [$];
    int                 exp_run_q [$];
    bench_pkg::nibble_t exp_nib_q [$];
    int                 done_cyc_q [$];

    int   pops [MAX_RUNS];
    int   strobes [MAX_RUNS];
    int   err [5];
    logic shown [5];
    int   errors;

    // ##############################
    // reference model

    // bank k = matrix * lanes + lane
    function automatic bench_pkg::word_t bank_word(input int k, input int d, input int i);
        bench_pkg::word_t seed;
        bench_pkg::word_t idx;
        seed = `BENCH_SEED_BASE + 32'(2 * k);
        idx  = 32'(d * DEPTH + i + 1);
        return (idx * seed) ^ seed;
    endfunction

    function automatic bench_pkg::nibble_t expected_nibble(
        input int               d,
        input int               i,
        input bench_pkg::word_t al,
        input bench_pkg::word_t be
    );
        bench_pkg::word_t r;
        bench_pkg::sig_t  x;
        x = '0;
        for (int l = 0; l < `BENCH_LANES; l++)
        begin
            r = al * bank_word(l, d, i) * bank_word(`BENCH_LANES + l, d, i) +
                be * bank_word(2 * `BENCH_LANES + l, d, i);
            x = x ^ r[7:0] ^ r[15:8] ^ r[23:16] ^ r[31:24];
        end
        return x[7:4] ^ x[3:0];
    endfunction

    // ##############################
    // reporting

    task automatic report_mismatch(input int idx, input string msg);
        err[idx]++;
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic report_problem(input int idx, input string msg);
        err[idx]++;
        errors++;
        $display("%s", msg);
    endtask

    task automatic show_test(input int idx);
        string name;
        case (idx)
            0:       name = "reset";
            1:       name = "signature values";
            2:       name = "run length";
            3:       name = "dataset rotation";
            default: name = "ignored starts";
        endcase
        $display("test %0d %-16s : %s, %0d errors", idx + 1, name,
                 (err[idx] == 0) ? "passed" : "failed", err[idx]);
        shown[idx] = 1'b1;
    endtask

    // ##############################
    // cycle step sampled mid-cycle where all signals are stable

    always @(negedge ap_clk)
    begin
        if (!arst_n)
        begin
            cyc        = 0;
            fill_left  = DEPTH;
            done_cnt   = 0;
            done_total = 0;
            dut_dones  = 0;
            runs       = 0;
            ignored    = 0;
            busy_from  = 0;
            busy_until = 0;
            errors     = 0;
            exp_cyc_q.delete();
            exp_run_q.delete();
            exp_nib_q.delete();
            done_cyc_q.delete();
            foreach (pops[r])
            begin
                pops[r]    = 0;
                strobes[r] = 0;
            end
            foreach (err[t])
            begin
                err[t]   = 0;
                shown[t] = 1'b0;
            end
        end
        else
        begin
            exp_done  = (done_cyc_q.size() > 0) && (done_cyc_q[0] == cyc);
            exp_idle  = !((cyc >= busy_from) && (cyc < busy_until));
            exp_valid = (exp_cyc_q.size() > 0) && (exp_cyc_q[0] == cyc);
            // second done of an interval drops loaded at once
            refill = (fill_left == 0) && exp_done && (done_cnt == `BENCH_UPDATE_INV - 1);
            loaded = (fill_left == 0) && !refill;
            if (exp_done)
                done_total++;
            if (ap_done === 1'b1)
                dut_dones++;

            if (ap_idle !== exp_idle)
                report_mismatch((runs == 0) ? 0 : 4,
                                $sformatf("ap_idle %b, expected %b", ap_idle, exp_idle));
            if (ap_done !== exp_done)
                report_mismatch((runs == 0) ? 0 : 2,
                                $sformatf("ap_done %b, expected %b", ap_done, exp_done));
            if (data_valid !== exp_valid)
                report_mismatch((runs == 0) ? 0 : 2,
                                $sformatf("data_valid %b, expected %b", data_valid, exp_valid));

            if (exp_valid)
            begin
                run = exp_run_q.pop_front();
                nib = exp_nib_q.pop_front();
                void'(exp_cyc_q.pop_front());
                if (data_valid === 1'b1)
                begin
                    strobes[run]++;
                    if (data_out !== nib)
                        report_mismatch((run < VALUE_RUNS) ? 1 : 3,
                                        $sformatf("run %0d address %0d signature %h, expected %h",
                                                  run, pops[run], data_out, nib));
                end
                pops[run]++;
                if (pops[run] == DEPTH && run == VALUE_RUNS - 1)
                    show_test(1);
                if (pops[run] == DEPTH && run == N_RUNS - 1)
                    show_test(3);
            end
            if (exp_done)
                void'(done_cyc_q.pop_front());

            // start seen by the next edge
            if (ap_start === 1'b1 && exp_idle && loaded && runs < MAX_RUNS)
            begin
                if (runs == 0)
                    show_test(0);
                dataset = (done_total / `BENCH_UPDATE_INV) % `BENCH_DATASET_NUM;
                // run starts next cycle
                // signature 7 cycles behind each address
                for (int i = 0; i < DEPTH; i++)
                begin
                    exp_cyc_q.push_back(cyc + 8 + i);
                    exp_nib_q.push_back(expected_nibble(dataset, i, alpha, beta));
                    exp_run_q.push_back(runs);
                end
                done_cyc_q.push_back(cyc + 68);
                busy_from  = cyc + 1;
                busy_until = cyc + 68;
                runs++;
            end
            else if (ap_start === 1'b1)
            begin
                ignored++;
            end

            if (refill)
            begin
                fill_left = DEPTH;
                done_cnt  = 0;
            end
            else
            begin
                if (fill_left > 0)
                    fill_left--;
                if (exp_done)
                    done_cnt++;
            end
            cyc++;
        end
    end

    // ##############################
    // end of run

    task automatic print_summary(output int total);
        int passed;
        for (int r = 0; r < runs && r < MAX_RUNS; r++)
        begin
            if (strobes[r] != DEPTH)
                report_problem(2, $sformatf("run %0d gave %0d signature strobes instead of %0d",
                                            r, strobes[r], DEPTH));
        end
        if (exp_cyc_q.size() != 0 || done_cyc_q.size() != 0)
            report_problem(2, "expected strobes or done pulses never arrived");
        if (dut_dones != runs)
            report_problem(4, $sformatf("%0d done pulses seen for %0d accepted runs",
                                        dut_dones, runs));
        $display("ignored start cycles: %0d, runs: %0d", ignored, runs);
        passed = 0;
        for (int t = 0; t < 5; t++)
        begin
            if (!shown[t])
                show_test(t);
            if (err[t] == 0)
                passed++;
        end
        $display("tests: 5, passed: %0d, failed: %0d, failed checks: %0d",
                 passed, 5 - passed, errors);
        total = errors;
    endtask

endmodule

// ==== hdl/bench_top.sv ====
`timescale 1ns/1ps
`include "bench_settings.svh"

module bench_top (
    input  logic               ap_clk,
    input  logic               arst_n,
    input  logic               ap_start,
    input  bench_pkg::word_t   alpha,
    input  bench_pkg::word_t   beta,
    output logic               ap_done,
    output logic               ap_idle,
    output bench_pkg::nibble_t data_out,
    output logic               data_valid
);

    logic                  bank_en;
    bench_pkg::bank_addr_t bank_addr;
    logic [3*`BENCH_LANES-1:0] banks_loaded;

    // first index is the matrix, A B C
    bench_pkg::word_t bank_dout [3][`BENCH_LANES];

    bench_pkg::lane_out_t results [`BENCH_LANES];

    // ##############################
    // banks, numbered matrix * lanes + lane

    for (genvar m = 0; m < 3; m++)
    begin : g_matrix
        for (genvar l = 0; l < `BENCH_LANES; l++)
        begin : g_lane
            kernel_ram #(
                .BANK_SEED  (32'(`BENCH_SEED_BASE + 2 * (m * `BENCH_LANES + l))),
                .BANK_DEPTH (`BENCH_BANK_DEPTH)
            ) u_bank (
                .ap_clk (ap_clk),
                .arst_n (arst_n),
                .done   (ap_done),
                .en     (bank_en),
                .addr   (bank_addr),
                .dout   (bank_dout[m][l]),
                .loaded (banks_loaded[m * `BENCH_LANES + l])
            );
        end
    end

    // ##############################
    // kernel and output fold

    scaled_mac_kernel u_kernel (
        .ap_clk       (ap_clk),
        .arst_n       (arst_n),
        .ap_start     (ap_start),
        .alpha        (alpha),
        .beta         (beta),
        .banks_loaded (banks_loaded),
        .en           (bank_en),
        .addr         (bank_addr),
        .a_dout       (bank_dout[0]),
        .b_dout       (bank_dout[1]),
        .c_dout       (bank_dout[2]),
        .results      (results),
        .ap_done      (ap_done),
        .ap_idle      (ap_idle)
    );

    signature_reducer u_reducer (
        .ap_clk     (ap_clk),
        .arst_n     (arst_n),
        .results    (results),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

// ==== hdl/signature_reducer.sv ====
`timescale 1ns/1ps
`include "bench_settings.svh"

module signature_reducer (
    input  logic                 ap_clk,
    input  logic                 arst_n,
    input  bench_pkg::lane_out_t results [`BENCH_LANES],
    output bench_pkg::nibble_t   data_out,
    output logic                 data_valid
);

    bench_pkg::sig_t x1 [4];
    logic [3:0]      v1;
    bench_pkg::sig_t x2 [2];
    logic [1:0]      v2;
    bench_pkg::sig_t x3;
    logic            v3;

    // take whichever side is valid, xor both, zero if neither
    function automatic bench_pkg::sig_t merge(
        input logic            v_lo,
        input logic            v_hi,
        input bench_pkg::sig_t lo,
        input bench_pkg::sig_t hi
    );
        bench_pkg::sig_t r;
        case ({v_hi, v_lo})
            2'b00:   r = '0;
            2'b01:   r = lo;
            2'b10:   r = hi;
            default: r = lo ^ hi;
        endcase
        return r;
    endfunction

    // ##############################
    // valid bits through all stages

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            v1         <= '0;
            v2         <= '0;
            v3         <= 1'b0;
            data_valid <= 1'b0;
        end
        else
        begin
            for (int l = 0; l < 4; l++)
            begin
                v1[l] <= results[l].write;
            end
            v2[0]      <= v1[0] | v1[1];
            v2[1]      <= v1[2] | v1[3];
            v3         <= v2[0] | v2[1];
            data_valid <= v3;
        end
    end

    // ##############################
    // data fold

    always_ff @(posedge ap_clk)
    begin
        // stage 1, bytes of each word
        for (int l = 0; l < 4; l++)
        begin
            x1[l] <= results[l].din[7:0] ^ results[l].din[15:8] ^
                     results[l].din[23:16] ^ results[l].din[31:24];
        end
        // stages 2 and 3, pairwise
        x2[0] <= merge(v1[0], v1[1], x1[0], x1[1]);
        x2[1] <= merge(v1[2], v1[3], x1[2], x1[3]);
        x3    <= merge(v2[0], v2[1], x2[0], x2[1]);
        // stage 4, nibbles
        data_out <= x3[7:4] ^ x3[3:0];
    end

endmodule

// ==== hdl/scaled_mac_kernel.sv ====
`timescale 1ns/1ps
`include "bench_settings.svh"

module scaled_mac_kernel (
    input  logic                  ap_clk,
    input  logic                  arst_n,
    input  logic                  ap_start,
    input  bench_pkg::word_t      alpha,
    input  bench_pkg::word_t      beta,
    input  logic [3*`BENCH_LANES-1:0] banks_loaded,
    output logic                  en,
    output bench_pkg::bank_addr_t addr,
    input  bench_pkg::word_t      a_dout [`BENCH_LANES],
    input  bench_pkg::word_t      b_dout [`BENCH_LANES],
    input  bench_pkg::word_t      c_dout [`BENCH_LANES],
    output bench_pkg::lane_out_t  results [`BENCH_LANES],
    output logic                  ap_done,
    output logic                  ap_idle
);

    localparam bench_pkg::bank_addr_t LAST_ADDR =
        bench_pkg::bank_addr_t'(`BENCH_BANK_DEPTH - 1);

    bench_pkg::run_state_t state;
    logic                  start_ok;
    bench_pkg::word_t      alpha_q;
    bench_pkg::word_t      beta_q;

    // valid chain, shared by all lanes since they move in step
    logic rd_valid;
    logic mul_valid;
    logic out_valid;

    bench_pkg::word_t mul_ab [`BENCH_LANES];
    bench_pkg::word_t mul_c [`BENCH_LANES];
    bench_pkg::word_t out_din [`BENCH_LANES];

    assign start_ok = ap_start && (state == bench_pkg::idle) && (&banks_loaded);
    assign ap_idle  = (state == bench_pkg::idle);

    // ##############################
    // run controller

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= bench_pkg::idle;
            en      <= 1'b0;
            addr    <= '0;
            ap_done <= 1'b0;
        end
        else
        begin
            ap_done <= 1'b0;
            case (state)
                bench_pkg::idle:
                begin
                    if (start_ok)
                    begin
                        en    <= 1'b1;
                        addr  <= '0;
                        state <= bench_pkg::sweep;
                    end
                end
                bench_pkg::sweep:
                begin
                    if (addr == LAST_ADDR)
                    begin
                        en    <= 1'b0;
                        state <= bench_pkg::drain;
                    end
                    else
                    begin
                        addr <= addr + 1'b1;
                    end
                end
                bench_pkg::drain:
                begin
                    // last element sits at the output, nothing behind it
                    if (out_valid && !mul_valid && !rd_valid)
                    begin
                        ap_done <= 1'b1;
                        state   <= bench_pkg::idle;
                    end
                end
                default:
                begin
                    state <= bench_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (start_ok)
        begin
            alpha_q <= alpha;
            beta_q  <= beta;
        end
    end

    // ##############################
    // multiply-add pipeline

    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_valid  <= 1'b0;
            mul_valid <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            rd_valid  <= en;
            mul_valid <= rd_valid;
            out_valid <= mul_valid;
        end
    end

    // low 32 bits kept throughout
    always_ff @(posedge ap_clk)
    begin
        for (int l = 0; l < `BENCH_LANES; l++)
        begin
            mul_ab[l]  <= alpha_q * a_dout[l] * b_dout[l];
            mul_c[l]   <= beta_q * c_dout[l];
            out_din[l] <= mul_ab[l] + mul_c[l];
        end
    end

    always_comb
    begin
        for (int l = 0; l < `BENCH_LANES; l++)
        begin
            results[l].write = out_valid;
            results[l].din   = out_din[l];
        end
    end

endmodule

// ==== hdl/kernel_ram.sv ====
`timescale 1ns/1ps
`include "bench_settings.svh"

module kernel_ram #(
    parameter bench_pkg::word_t BANK_SEED = `BENCH_SEED_BASE,
    parameter int unsigned BANK_DEPTH = `BENCH_BANK_DEPTH
) (
    input  logic                  ap_clk,
    input  logic                  arst_n,
    input  logic                  done,
    input  logic                  en,
    input  bench_pkg::bank_addr_t addr,
    output bench_pkg::word_t      dout,
    output logic                  loaded
);

    localparam int unsigned CNT_W = $clog2(`BENCH_UPDATE_INV + 1);

    bench_pkg::word_t        mem [BANK_DEPTH];
    bench_pkg::ram_state_t   state;
    bench_pkg::bank_addr_t   fill_addr;
    bench_pkg::dataset_idx_t dataset;
    bench_pkg::word_t        gen_acc;
    logic [CNT_W-1:0]        done_cnt;
    logic                    refill_due;

    // this done pulse completes the update interval
    assign refill_due = (state == bench_pkg::ready) && done &&
                        (done_cnt == CNT_W'(`BENCH_UPDATE_INV - 1));

    // drop loaded together with the last done, so no start slips in
    assign loaded = (state == bench_pkg::ready) && !refill_due;

    // ##############################
    // refill engine

    // gen_acc runs as (d * depth + i + 1) * seed, one seed added per word
    always_ff @(posedge ap_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= bench_pkg::fill;
            fill_addr <= '0;
            dataset   <= '0;
            gen_acc   <= BANK_SEED;
            done_cnt  <= '0;
        end
        else
        begin
            case (state)
                bench_pkg::fill:
                begin
                    fill_addr <= fill_addr + 1'b1;
                    gen_acc   <= gen_acc + BANK_SEED;
                    if (fill_addr == bench_pkg::bank_addr_t'(BANK_DEPTH - 1))
                    begin
                        fill_addr <= '0;
                        state     <= bench_pkg::ready;
                    end
                end
                bench_pkg::ready:
                begin
                    if (refill_due)
                    begin
                        done_cnt <= '0;
                        state    <= bench_pkg::fill;
                        // back to dataset 0 restarts the product chain
                        if (dataset == bench_pkg::dataset_idx_t'(`BENCH_DATASET_NUM - 1))
                        begin
                            dataset <= '0;
                            gen_acc <= BANK_SEED;
                        end
                        else
                        begin
                            dataset <= dataset + 1'b1;
                        end
                    end
                    else if (done)
                    begin
                        done_cnt <= done_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= bench_pkg::fill;
                end
            endcase
        end
    end

    // ##############################
    // storage and read port

    always_ff @(posedge ap_clk)
    begin
        if (state == bench_pkg::fill)
        begin
            mem[fill_addr] <= gen_acc ^ BANK_SEED;
        end
        if (en && loaded)
        begin
            dout <= mem[addr];
        end
    end

endmodule

// ==== hdl/bench_pkg.sv ====
`include "bench_settings.svh"

package bench_pkg;

    // ##############################
    // vector types

    typedef logic [31:0] word_t;
    typedef logic [`BENCH_BANK_AW-1:0] bank_addr_t;
    typedef logic [2:0] dataset_idx_t;
    typedef logic [7:0] sig_t;
    typedef logic [3:0] nibble_t;

    // one lane result, write strobe with its data
    typedef struct packed {
        logic  write;
        word_t din;
    } lane_out_t;

    // ##############################
    // state machines

    // bank refill engine
    typedef enum logic {
        fill,
        ready
    } ram_state_t;

    // kernel run controller
    typedef enum logic [1:0] {
        idle,
        sweep,
        drain
    } run_state_t;

endpackage

// ==== hdl/bench_settings.svh ====
`ifndef BENCH_SETTINGS_SVH
`define BENCH_SETTINGS_SVH

// ##############################
// partitioning

// lanes per matrix, one bank of A, B and C each
`define BENCH_LANES 4

// ##############################
// bank geometry

`define BENCH_BANK_DEPTH 64
`define BENCH_BANK_AW 6

// ##############################
// dataset rotation

`define BENCH_DATASET_NUM 8

// completed runs before a bank refills
`define BENCH_UPDATE_INV 2

// odd, so every bank seed stays odd
`define BENCH_SEED_BASE 32'h9e3779b1

`endif
